// File: project.f
+incdir+verif
verilog/alu_pkg.sv
verilog/alu_operand_if.sv
verilog/alu_issue_stage.sv
verilog/alu_int_exec.sv
verilog/alu_mul_iter.sv
verilog/alu_pipe.sv
verif/alu_pipe_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module alu_pipe_tb -o alu_pipe_sim
./obj_dir/alu_pipe_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi

// File: verif/alu_pipe_model.svh
// ------------------------------
// reference decode, execute and multiply functions
// ------------------------------
`ifndef ALU_PIPE_MODEL_SVH
`define ALU_PIPE_MODEL_SVH

// multiply ops: OP major opcode, funct7 = 1, funct3 below 4
function automatic logic model_is_mul(input logic [31:0] inst);
  return (inst[6:0] == 7'b0110011) && (inst[31:25] == 7'b0000001) && !inst[14];
endfunction

// full 64-bit product, operands extended per funct3
function automatic logic [63:0] model_product(input logic [2:0] f3,
                                              input logic [31:0] a,
                                              input logic [31:0] b);
  logic [63:0] ea;
  logic [63:0] eb;
  ea = (f3 == 3'b011) ? {32'h0, a} : {{32{a[31]}}, a};  // only mulhu takes rs1 unsigned
  eb = f3[1] ? {32'h0, b} : {{32{b[31]}}, b};           // mulhsu and mulhu
  return ea * eb;
endfunction

function automatic logic [31:0] model_exec(input logic [31:0] inst,
                                           input logic [31:0] a,
                                           input logic [31:0] b);
  logic [6:0]  opc;
  logic [6:0]  f7;
  logic [2:0]  f3;
  logic [31:0] imm;
  logic [63:0] prod;
  logic [31:0] res;
  opc  = inst[6:0];
  f7   = inst[31:25];
  f3   = inst[14:12];
  imm  = {{20{inst[31]}}, inst[31:20]};
  prod = model_product(f3, a, b);
  res  = 32'h0;  // illegal and unsupported encodings
  if (opc == 7'b0110111) begin
    res = {inst[31:12], 12'h000};
  end else if (opc == 7'b0010011) begin
    case (f3)
      3'b000: res = a + imm;
      3'b010: res = {31'h0, $signed(a) < $signed(imm)};
      3'b011: res = {31'h0, a < imm};
      3'b100: res = a ^ imm;
      3'b110: res = a | imm;
      3'b111: res = a & imm;
      3'b001: if (f7 == 7'h00) res = a << inst[24:20];
      default: begin
        if (f7 == 7'h00) res = a >> inst[24:20];
        else if (f7 == 7'h20) res = $signed(a) >>> inst[24:20];
      end
    endcase
  end else if (opc == 7'b0110011) begin
    if (model_is_mul(inst)) begin
      res = (f3 == 3'b000) ? prod[31:0] : prod[63:32];
    end else if (f7 == 7'h00) begin
      case (f3)
        3'b000: res = a + b;
        3'b001: res = a << b[4:0];
        3'b010: res = {31'h0, $signed(a) < $signed(b)};
        3'b011: res = {31'h0, a < b};
        3'b100: res = a ^ b;
        3'b101: res = a >> b[4:0];
        3'b110: res = a | b;
        default: res = a & b;
      endcase
    end else if (f7 == 7'h20 && f3 == 3'b000) begin
      res = a - b;
    end else if (f7 == 7'h20 && f3 == 3'b101) begin
      res = $signed(a) >>> b[4:0];
    end
  end
  return res;
endfunction

`endif

// File: verif/alu_pipe_tb.sv
// ------------------------------
// testbench: clock, reset, stimulus, scoreboard
// ------------------------------
`timescale 1ns/1ps

module alu_pipe_tb;

  logic           i_clk;
  logic           i_reset_n;
  logic           i_issue_valid;
  alu_pkg::inst_t i_issue_inst;
  alu_pkg::xlen_t i_issue_rs1;
  alu_pkg::xlen_t i_issue_rs2;
  alu_pkg::tag_t  i_issue_tag;
  logic           i_kill;
  logic           o_wb_valid;
  alu_pkg::tag_t  o_wb_tag;
  alu_pkg::rd_t   o_wb_rd;
  alu_pkg::xlen_t o_wb_data;
  logic           o_mul_credit;

  integer seed = 32'h61d3;
  int     errors = 0;
  int     timeouts = 0;
  int     cyc = 0;  // bumped on every falling edge
  logic   issued_any = 1'b0;
  logic   mul_outstanding = 1'b0;
  logic [3:0] next_tag = 4'h0;

  // scoreboard, one slot per tag
  logic        pending [16];
  logic [31:0] exp_data [16];
  logic [4:0]  exp_rd [16];
  logic        exp_mul [16];
  int          exp_cycle [16];

  // {funct7, funct3} of the register-register ALU ops
  logic [9:0] alu_r_ops [10] = '{{7'h00, 3'd0}, {7'h20, 3'd0}, {7'h00, 3'd1}, {7'h00, 3'd2},
                                 {7'h00, 3'd3}, {7'h00, 3'd4}, {7'h00, 3'd5}, {7'h20, 3'd5},
                                 {7'h00, 3'd6}, {7'h00, 3'd7}};
  logic [31:0] ext_a [6] = '{32'h80000000, 32'h80000000, 32'hffffffff,
                             32'h7fffffff, 32'hffffffff, 32'h00000000};
  logic [31:0] ext_b [6] = '{32'h80000000, 32'hffffffff, 32'hffffffff,
                             32'h80000000, 32'h7fffffff, 32'hffffffff};

  `include "alu_pipe_model.svh"

  alu_pipe #(
    .MUL_UNROLL (8)
  ) UUT (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_issue_valid (i_issue_valid),
    .i_issue_inst  (i_issue_inst),
    .i_issue_rs1   (i_issue_rs1),
    .i_issue_rs2   (i_issue_rs2),
    .i_issue_tag   (i_issue_tag),
    .i_kill        (i_kill),
    .o_wb_valid    (o_wb_valid),
    .o_wb_tag      (o_wb_tag),
    .o_wb_rd       (o_wb_rd),
    .o_wb_data     (o_wb_data),
    .o_mul_credit  (o_mul_credit)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  // ------------------------------
  // helpers
  // ------------------------------
  task automatic record_failure(input string msg);
    $display("FAIL at %0t: %s", $time, msg);
    errors++;
  endtask

  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  function automatic logic [4:0] rnd_rd();
    logic [31:0] r;
    r = rnd();
    return r[4:0];
  endfunction

  function automatic logic [31:0] enc_r(input logic [9:0] f, input logic [4:0] rd);
    return {f[9:3], 5'd2, 5'd1, f[2:0], rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {imm, 5'd1, f3, rd, 7'b0010011};
  endfunction

  // drive at the falling edge, book the op at the edge that samples it
  task automatic issue(input logic [31:0] inst, input logic [31:0] a, input logic [31:0] b,
                       input logic kill);
    int waited;
    logic [3:0] t;
    waited = 0;
    while (model_is_mul(inst) && mul_outstanding && waited < 200) begin
      @(negedge i_clk);
      i_issue_valid = 1'b0;  // nothing issued while the credit is out
      i_kill        = 1'b0;
      @(posedge i_clk);
      waited++;
    end
    if (model_is_mul(inst) && mul_outstanding) begin
      $display("timeout: multiplier credit was not returned before the next multiply");
      timeouts++;
    end
    @(negedge i_clk);
    i_issue_valid = 1'b1;
    i_issue_inst  = inst;
    i_issue_rs1   = a;
    i_issue_rs2   = b;
    i_issue_tag   = next_tag;
    i_kill        = kill;
    @(posedge i_clk);
    issued_any = 1'b1;
    t = next_tag;
    next_tag = next_tag + 4'h1;
    if (kill) begin
      for (int i = 0; i < 16; i++) pending[i] = 1'b0;  // all work in flight is gone
    end else begin
      assert (!pending[t]) else record_failure($sformatf("tag %0d reused while in flight", t));
      pending[t]   = 1'b1;
      exp_data[t]  = model_exec(inst, a, b);
      exp_rd[t]    = inst[11:7];
      exp_mul[t]   = model_is_mul(inst);
      exp_cycle[t] = cyc + 2;
      if (exp_mul[t]) mul_outstanding = 1'b1;
    end
  endtask

  task automatic drain();
    int waited;
    int left;
    waited = 0;
    @(negedge i_clk);
    i_issue_valid = 1'b0;
    i_kill        = 1'b0;
    @(posedge i_clk);
    left = 1;
    while (left != 0 && waited < 200) begin
      left = mul_outstanding ? 1 : 0;
      for (int i = 0; i < 16; i++) left += pending[i] ? 1 : 0;
      if (left != 0) begin
        @(posedge i_clk);
        waited++;
      end
    end
    if (left != 0) begin
      $display("timeout: %0d results or credits never came back", left);
      timeouts++;
    end
  endtask

  // ------------------------------
  // writeback monitor
  // ------------------------------
  task automatic check_writeback();
    logic [3:0] t;
    t = o_wb_tag;
    assert (pending[t]) else record_failure($sformatf("tag %0d written back, not in flight", t));
    if (pending[t]) begin
      assert (o_wb_rd == exp_rd[t])
        else record_failure($sformatf("tag %0d rd %0d, expected %0d", t, o_wb_rd, exp_rd[t]));
      assert (o_wb_data == exp_data[t])
        else record_failure($sformatf("tag %0d data %h, expected %h", t, o_wb_data, exp_data[t]));
      if (exp_mul[t]) begin
        assert (o_mul_credit) else record_failure("multiply written back without credit pulse");
      end else begin
        assert (cyc == exp_cycle[t])
          else record_failure($sformatf("tag %0d at cycle %0d, expected %0d", t, cyc,
                                        exp_cycle[t]));
      end
      pending[t] = 1'b0;
    end
  endtask

  always @(negedge i_clk) begin
    cyc = cyc + 1;
    if (i_reset_n) begin
      if (!issued_any) begin
        assert (!o_wb_valid && !o_mul_credit)
          else record_failure("writeback or credit active before the first issue");
      end
      if (o_wb_valid) check_writeback();
      if (o_mul_credit) begin
        assert (mul_outstanding) else record_failure("credit pulse with no multiply outstanding");
        mul_outstanding = 1'b0;
      end
    end
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  initial begin
    for (int i = 0; i < 16; i++) pending[i] = 1'b0;
    i_reset_n     = 1'b0;
    i_issue_valid = 1'b0;
    i_issue_inst  = '0;
    i_issue_rs1   = '0;
    i_issue_rs2   = '0;
    i_issue_tag   = '0;
    i_kill        = 1'b0;
    repeat (5) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;
    repeat (4) @(posedge i_clk);  // quiet outputs before the first issue

    // register-register ops back to back
    repeat (3) begin
      for (int i = 0; i < 10; i++) issue(enc_r(alu_r_ops[i], rnd_rd()), rnd(), rnd(), 1'b0);
    end
    drain();

    // immediate forms, LUI, illegal encodings
    repeat (4) begin
      issue(enc_i(12'(rnd()), 3'd0, rnd_rd()), rnd(), rnd(), 1'b0);
      issue(enc_i(12'(rnd()), 3'd2, rnd_rd()), rnd(), rnd(), 1'b0);
      issue(enc_i(12'(rnd()), 3'd3, rnd_rd()), rnd(), rnd(), 1'b0);
      issue(enc_i(12'(rnd()), 3'd4, rnd_rd()), rnd(), rnd(), 1'b0);
      issue(enc_i(12'(rnd()), 3'd6, rnd_rd()), rnd(), rnd(), 1'b0);
      issue(enc_i(12'(rnd()), 3'd7, rnd_rd()), rnd(), rnd(), 1'b0);
      issue(enc_i({7'h00, rnd_rd()}, 3'd1, rnd_rd()), rnd(), rnd(), 1'b0);
      issue(enc_i({7'h00, rnd_rd()}, 3'd5, rnd_rd()), rnd(), rnd(), 1'b0);
      issue(enc_i({7'h20, rnd_rd()}, 3'd5, rnd_rd()), rnd(), rnd(), 1'b0);
      issue({rnd() & 32'hfffff000} | {20'h0, rnd_rd(), 7'b0110111}, rnd(), rnd(), 1'b0);
    end
    issue({25'h0, 7'b1111111}, rnd(), rnd(), 1'b0);             // unknown opcode
    issue(enc_r({7'h01, 3'd4}, rnd_rd()), rnd(), rnd(), 1'b0);  // div, not supported
    issue(enc_i({7'h20, 5'd3}, 3'd1, rnd_rd()), rnd(), rnd(), 1'b0);
    drain();

    // multiplies, extremes then random
    for (int f = 0; f < 4; f++) begin
      for (int i = 0; i < 6; i++) issue(enc_r({7'h01, 3'(f)}, rnd_rd()), ext_a[i], ext_b[i], 1'b0);
      repeat (4) issue(enc_r({7'h01, 3'(f)}, rnd_rd()), rnd(), rnd(), 1'b0);
    end
    drain();

    // ALU stream while a multiply finishes
    for (int f = 0; f < 4; f++) begin
      issue(enc_r({7'h01, 3'(f)}, rnd_rd()), rnd(), rnd(), 1'b0);
      repeat (12) issue(enc_r(alu_r_ops[int'(rnd_rd()) % 10], rnd_rd()), rnd(), rnd(), 1'b0);
      drain();
    end

    // kill with an ALU op in ex1 and a multiply running
    issue(enc_r({7'h01, 3'd1}, rnd_rd()), rnd(), rnd(), 1'b0);
    issue(enc_r(alu_r_ops[0], rnd_rd()), rnd(), rnd(), 1'b0);
    issue(enc_r(alu_r_ops[1], rnd_rd()), rnd(), rnd(), 1'b1);
    drain();
    issue(enc_r(alu_r_ops[5], rnd_rd()), rnd(), rnd(), 1'b0);
    issue(enc_r({7'h01, 3'd0}, rnd_rd()), rnd(), rnd(), 1'b0);
    issue(enc_i(12'(rnd()), 3'd0, rnd_rd()), rnd(), rnd(), 1'b0);
    drain();
    repeat (5) @(posedge i_clk);  // catch any late writeback of killed tags

    $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: verilog/alu_pipe.sv
// ------------------------------
// RV32 execution pipe top, writeback merge
// ------------------------------
`timescale 1ns/1ps

module alu_pipe #(
  parameter int MUL_UNROLL = 8
) (
  input  logic           i_clk,
  input  logic           i_reset_n,
  input  logic           i_issue_valid,
  input  alu_pkg::inst_t i_issue_inst,
  input  alu_pkg::xlen_t i_issue_rs1,
  input  alu_pkg::xlen_t i_issue_rs2,
  input  alu_pkg::tag_t  i_issue_tag,
  input  logic           i_kill,
  output logic           o_wb_valid,
  output alu_pkg::tag_t  o_wb_tag,
  output alu_pkg::rd_t   o_wb_rd,
  output alu_pkg::xlen_t o_wb_data,
  output logic           o_mul_credit
);

  logic           w_int_valid;
  alu_pkg::tag_t  w_int_tag;
  alu_pkg::rd_t   w_int_rd;
  alu_pkg::xlen_t w_int_data;

  logic           w_mul_valid;
  alu_pkg::tag_t  w_mul_tag;
  alu_pkg::rd_t   w_mul_rd;
  alu_pkg::xlen_t w_mul_data;

  alu_operand_if u_opnd_if ();

  // ------------------------------
  // ex0 -> ex1
  // ------------------------------
  alu_issue_stage u_issue (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_valid   (i_issue_valid),
    .i_inst    (i_issue_inst),
    .i_rs1     (i_issue_rs1),
    .i_rs2     (i_issue_rs2),
    .i_tag     (i_issue_tag),
    .i_kill    (i_kill),
    .o_opnd    (u_opnd_if.issue)
  );

  // ------------------------------
  // execute units
  // ------------------------------
  alu_int_exec u_int (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_kill    (i_kill),
    .i_opnd    (u_opnd_if.exec),
    .o_valid   (w_int_valid),
    .o_tag     (w_int_tag),
    .o_rd      (w_int_rd),
    .o_data    (w_int_data)
  );

  alu_mul_iter #(
    .MUL_UNROLL (MUL_UNROLL)
  ) u_mul (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_kill    (i_kill),
    .i_opnd    (u_opnd_if.exec),
    .i_wb_busy (w_int_valid),  // ALU result has the port
    .o_valid   (w_mul_valid),
    .o_tag     (w_mul_tag),
    .o_rd      (w_mul_rd),
    .o_data    (w_mul_data),
    .o_credit  (o_mul_credit)
  );

  // writeback merge, integer first
  assign o_wb_valid = w_int_valid | w_mul_valid;
  assign o_wb_tag   = w_int_valid ? w_int_tag  : w_mul_tag;
  assign o_wb_rd    = w_int_valid ? w_int_rd   : w_mul_rd;
  assign o_wb_data  = w_int_valid ? w_int_data : w_mul_data;

endmodule

// File: verilog/alu_mul_iter.sv
// ------------------------------
// iterative multiplier, result hold and credit return
// ------------------------------
`timescale 1ns/1ps

module alu_mul_iter #(
  parameter int MUL_UNROLL = 8
) (
  input  logic           i_clk,
  input  logic           i_reset_n,
  input  logic           i_kill,
  alu_operand_if.exec    i_opnd,
  input  logic           i_wb_busy,
  output logic           o_valid,
  output alu_pkg::tag_t  o_tag,
  output alu_pkg::rd_t   o_rd,
  output alu_pkg::xlen_t o_data,
  output logic           o_credit
);

  localparam int STEPS = alu_pkg::XLEN / MUL_UNROLL;
  localparam int CNT_W = (STEPS > 1) ? $clog2(STEPS) : 1;

  typedef logic [2*alu_pkg::XLEN-1:0] dword_t;

  alu_pkg::mul_state_e r_state;
  logic [CNT_W-1:0]    r_cnt;
  logic                r_kill_credit;
  logic                r_hi;       // high word wanted
  dword_t              r_acc;
  dword_t              r_mcand;    // sign-extended rs1, shifted each step
  alu_pkg::xlen_t      r_mplier;   // low 32 bits of rs2, consumed from lsb
  dword_t              w_partial;
  logic                w_start;
  logic [alu_pkg::XLEN:0] w_a33;
  logic [alu_pkg::XLEN:0] w_b33;

  assign w_start = i_opnd.valid & alu_pkg::is_mul_op(i_opnd.op);

  // 33-bit operands, sign bit only for the signed sides
  assign w_a33 = {i_opnd.rs1[alu_pkg::XLEN-1] & (i_opnd.op != alu_pkg::OP_MULHU), i_opnd.rs1};
  assign w_b33 = {i_opnd.rs2[alu_pkg::XLEN-1] &
                  (i_opnd.op == alu_pkg::OP_MULH || i_opnd.op == alu_pkg::OP_MUL), i_opnd.rs2};

  always_comb begin
    w_partial = '0;
    for (int j = 0; j < MUL_UNROLL; j++) begin
      if (r_mplier[j]) begin
        w_partial = w_partial + (r_mcand << j);
      end
    end
  end

  // ------------------------------
  // control FSM
  // ------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state       <= alu_pkg::MUL_IDLE;
      r_cnt         <= '0;
      r_kill_credit <= 1'b0;
    end else begin
      // killed op returns its credit next cycle, unless already written now
      r_kill_credit <= i_kill & ((r_state == alu_pkg::MUL_IDLE & w_start) |
                                 (r_state == alu_pkg::MUL_RUN) |
                                 (r_state == alu_pkg::MUL_HOLD & ~o_valid));
      if (i_kill) begin
        r_state <= alu_pkg::MUL_IDLE;
      end else begin
        case (r_state)
          alu_pkg::MUL_IDLE: if (w_start) begin
            r_state <= alu_pkg::MUL_RUN;
            r_cnt   <= CNT_W'(STEPS - 1);
          end
          alu_pkg::MUL_RUN: begin
            r_cnt <= r_cnt - 1'b1;
            if (r_cnt == '0) r_state <= alu_pkg::MUL_HOLD;
          end
          alu_pkg::MUL_HOLD: if (o_valid) r_state <= alu_pkg::MUL_IDLE;
          default: r_state <= alu_pkg::MUL_IDLE;
        endcase
      end
    end
  end

  // datapath, b sign handled by preloading -(a << 32)
  always_ff @(posedge i_clk) begin
    if (r_state == alu_pkg::MUL_IDLE && w_start) begin
      r_mcand  <= {{(alu_pkg::XLEN-1){w_a33[alu_pkg::XLEN]}}, w_a33};
      r_mplier <= w_b33[alu_pkg::XLEN-1:0];
      r_acc    <= w_b33[alu_pkg::XLEN] ? (dword_t'(0) - {w_a33[alu_pkg::XLEN-1:0],
                                                         {alu_pkg::XLEN{1'b0}}}) : '0;
      r_hi     <= (i_opnd.op != alu_pkg::OP_MUL);
      o_tag    <= i_opnd.tag;
      o_rd     <= i_opnd.rd;
    end else if (r_state == alu_pkg::MUL_RUN) begin
      r_acc    <= r_acc + w_partial;
      r_mcand  <= r_mcand << MUL_UNROLL;
      r_mplier <= r_mplier >> MUL_UNROLL;
    end
  end

  // ALU owns the port when both want it
  assign o_valid  = (r_state == alu_pkg::MUL_HOLD) & ~i_wb_busy;
  assign o_data   = r_hi ? r_acc[2*alu_pkg::XLEN-1:alu_pkg::XLEN] : r_acc[alu_pkg::XLEN-1:0];
  assign o_credit = o_valid | r_kill_credit;

endmodule

// File: verilog/alu_int_exec.sv
// ------------------------------
// ex1 integer ALU with registered ex2 result
// ------------------------------
`timescale 1ns/1ps

module alu_int_exec (
  input  logic           i_clk,
  input  logic           i_reset_n,
  input  logic           i_kill,
  alu_operand_if.exec    i_opnd,
  output logic           o_valid,
  output alu_pkg::tag_t  o_tag,
  output alu_pkg::rd_t   o_rd,
  output alu_pkg::xlen_t o_data
);

  logic                                 w_take;
  logic [$clog2(alu_pkg::XLEN)-1:0]     w_shamt;
  alu_pkg::xlen_t                       w_result;

  // everything the multiplier does not own, illegal included
  assign w_take  = i_opnd.valid & ~alu_pkg::is_mul_op(i_opnd.op);
  assign w_shamt = i_opnd.rs2[$clog2(alu_pkg::XLEN)-1:0];

  always_comb begin
    case (i_opnd.op)
      alu_pkg::OP_LUI:  w_result = i_opnd.rs2;  // U-immediate already in rs2
      alu_pkg::OP_ADD:  w_result = i_opnd.rs1 + i_opnd.rs2;
      alu_pkg::OP_SUB:  w_result = i_opnd.rs1 - i_opnd.rs2;
      alu_pkg::OP_XOR:  w_result = i_opnd.rs1 ^ i_opnd.rs2;
      alu_pkg::OP_OR:   w_result = i_opnd.rs1 | i_opnd.rs2;
      alu_pkg::OP_AND:  w_result = i_opnd.rs1 & i_opnd.rs2;
      alu_pkg::OP_SLL:  w_result = i_opnd.rs1 << w_shamt;
      alu_pkg::OP_SRL:  w_result = i_opnd.rs1 >> w_shamt;
      alu_pkg::OP_SRA:  w_result = $signed(i_opnd.rs1) >>> w_shamt;
      alu_pkg::OP_SLT: begin
        w_result = {{(alu_pkg::XLEN-1){1'b0}}, $signed(i_opnd.rs1) < $signed(i_opnd.rs2)};
      end
      alu_pkg::OP_SLTU: begin
        w_result = {{(alu_pkg::XLEN-1){1'b0}}, i_opnd.rs1 < i_opnd.rs2};
      end
      default:          w_result = '0;  // illegal writes back zero
    endcase
  end

  // ------------------------------
  // ex2 result register
  // ------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= w_take & ~i_kill;
    end
  end

  always_ff @(posedge i_clk) begin
    o_data <= w_result;
    o_tag  <= i_opnd.tag;
    o_rd   <= i_opnd.rd;
  end

endmodule

// File: verilog/alu_issue_stage.sv
// ------------------------------
// ex0 stage: decode, immediate build, ex1 register
// ------------------------------
`timescale 1ns/1ps

module alu_issue_stage (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_valid,
  input  alu_pkg::inst_t   i_inst,
  input  alu_pkg::xlen_t   i_rs1,
  input  alu_pkg::xlen_t   i_rs2,
  input  alu_pkg::tag_t    i_tag,
  input  logic             i_kill,
  alu_operand_if.issue     o_opnd
);

  alu_pkg::alu_op_e  w_op;
  alu_pkg::imm_sel_e w_imm_sel;
  alu_pkg::xlen_t    w_rs2;
  logic [6:0]        w_opcode;
  logic [2:0]        w_funct3;
  logic [6:0]        w_funct7;

  assign w_opcode = i_inst[6:0];
  assign w_funct3 = i_inst[14:12];
  assign w_funct7 = i_inst[31:25];

  // ------------------------------
  // decode
  // ------------------------------
  always_comb begin
    w_op      = alu_pkg::OP_ILLEGAL;
    w_imm_sel = alu_pkg::IMM_NONE;
    case (w_opcode)
      alu_pkg::OPC_LUI: begin
        w_op      = alu_pkg::OP_LUI;
        w_imm_sel = alu_pkg::IMM_U;
      end
      alu_pkg::OPC_OP: begin
        case ({w_funct7, w_funct3})
          {7'b0000000, 3'b000}: w_op = alu_pkg::OP_ADD;
          {7'b0100000, 3'b000}: w_op = alu_pkg::OP_SUB;
          {7'b0000000, 3'b001}: w_op = alu_pkg::OP_SLL;
          {7'b0000000, 3'b010}: w_op = alu_pkg::OP_SLT;
          {7'b0000000, 3'b011}: w_op = alu_pkg::OP_SLTU;
          {7'b0000000, 3'b100}: w_op = alu_pkg::OP_XOR;
          {7'b0000000, 3'b101}: w_op = alu_pkg::OP_SRL;
          {7'b0100000, 3'b101}: w_op = alu_pkg::OP_SRA;
          {7'b0000000, 3'b110}: w_op = alu_pkg::OP_OR;
          {7'b0000000, 3'b111}: w_op = alu_pkg::OP_AND;
          {7'b0000001, 3'b000}: w_op = alu_pkg::OP_MUL;
          {7'b0000001, 3'b001}: w_op = alu_pkg::OP_MULH;
          {7'b0000001, 3'b010}: w_op = alu_pkg::OP_MULHSU;
          {7'b0000001, 3'b011}: w_op = alu_pkg::OP_MULHU;
          default:              w_op = alu_pkg::OP_ILLEGAL;  // div and unknown
        endcase
      end
      alu_pkg::OPC_OP_IMM: begin
        w_imm_sel = alu_pkg::IMM_I;
        case (w_funct3)
          3'b000: w_op = alu_pkg::OP_ADD;
          3'b010: w_op = alu_pkg::OP_SLT;
          3'b011: w_op = alu_pkg::OP_SLTU;
          3'b100: w_op = alu_pkg::OP_XOR;
          3'b110: w_op = alu_pkg::OP_OR;
          3'b111: w_op = alu_pkg::OP_AND;
          default: begin
            // shifts, funct7 picks logical or arithmetic
            w_imm_sel = alu_pkg::IMM_SH;
            if (w_funct3 == 3'b001 && w_funct7 == 7'b0000000) begin
              w_op = alu_pkg::OP_SLL;
            end else if (w_funct3 == 3'b101 && w_funct7 == 7'b0000000) begin
              w_op = alu_pkg::OP_SRL;
            end else if (w_funct3 == 3'b101 && w_funct7 == 7'b0100000) begin
              w_op = alu_pkg::OP_SRA;
            end
          end
        endcase
      end
      default: w_op = alu_pkg::OP_ILLEGAL;
    endcase
  end

  // second operand mux
  always_comb begin
    case (w_imm_sel)
      alu_pkg::IMM_I:  w_rs2 = {{(alu_pkg::XLEN-12){i_inst[31]}}, i_inst[31:20]};
      alu_pkg::IMM_SH: w_rs2 = {{(alu_pkg::XLEN-5){1'b0}}, i_inst[24:20]};
      alu_pkg::IMM_U:  w_rs2 = {i_inst[31:12], 12'h000};
      default:         w_rs2 = i_rs2;
    endcase
  end

  // ------------------------------
  // ex1 register
  // ------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_opnd.valid <= 1'b0;
    end else begin
      o_opnd.valid <= i_valid & ~i_kill;  // kill drops same-cycle issue
    end
  end

  always_ff @(posedge i_clk) begin
    o_opnd.op  <= w_op;
    o_opnd.rs1 <= i_rs1;
    o_opnd.rs2 <= w_rs2;
    o_opnd.tag <= i_tag;
    o_opnd.rd  <= i_inst[11:7];
  end

endmodule

// File: verilog/alu_operand_if.sv
// ------------------------------
// decoded op and operands, issue stage to execute units
// ------------------------------
`timescale 1ns/1ps

interface alu_operand_if;

  logic            valid;  // one cycle per op
  alu_pkg::alu_op_e op;
  alu_pkg::xlen_t  rs1;
  alu_pkg::xlen_t  rs2;    // immediate already merged in
  alu_pkg::tag_t   tag;
  alu_pkg::rd_t    rd;

  modport issue (
    output valid, op, rs1, rs2, tag, rd
  );

  modport exec (
    input valid, op, rs1, rs2, tag, rd
  );

endinterface

// File: verilog/alu_pkg.sv
// ------------------------------
// shared widths, vector types, op and immediate enums, opcodes
// ------------------------------

package alu_pkg;

  localparam int XLEN  = 32;
  localparam int TAG_W = 4;

  typedef logic [XLEN-1:0]  xlen_t;
  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [4:0]       rd_t;
  typedef logic [31:0]      inst_t;

  // major opcodes, inst[6:0]
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  typedef enum logic [4:0] {
    OP_LUI, OP_ADD, OP_SUB, OP_XOR, OP_OR, OP_AND,
    OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
    OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
    OP_ILLEGAL
  } alu_op_e;

  // second operand source
  typedef enum logic [1:0] {
    IMM_NONE,  // rs2 as issued
    IMM_I,     // sign-extended inst[31:20]
    IMM_SH,    // shamt, inst[24:20]
    IMM_U      // inst[31:12] << 12
  } imm_sel_e;

  typedef enum logic [1:0] {
    MUL_IDLE,
    MUL_RUN,
    MUL_HOLD
  } mul_state_e;

  // ops owned by the multiplier
  function automatic logic is_mul_op(alu_op_e op);
    return (op == OP_MUL) || (op == OP_MULH) || (op == OP_MULHSU) || (op == OP_MULHU);
  endfunction

endpackage
